// File: bitGenPkg.sv
`default_nettype none

package bitGenPkg;

	// Screen coordinates, tile-map addresses and tile codes share one width
	localparam int coordWidth = 16;

	typedef logic [coordWidth-1:0] coordWord;
	typedef logic [7:0] colorByte;

	// Column plus four times the row inside a 4x4 tile
	typedef logic [3:0] pixelIndex;

	// Tile-map geometry
	localparam int tileShift = 2;
	localparam coordWord tileMapBase = 16'd40000;
	localparam coordWord tilesPerRow = 16'd160;

	// Solid squares
	localparam coordWord glyphBlack = 16'd0;
	localparam coordWord glyphBlue = 16'd1;
	localparam coordWord glyphYellow = 16'd2;

	// First code of each player's seven path glyphs
	localparam coordWord bluePathBase = 16'd3;
	localparam coordWord yellowPathBase = 16'd28;

	// Offset from the path base, in code order
	typedef enum logic [2:0] {
		shapeHorizontal,
		shapeVertical,
		shapeCorner,
		shapeLeftDown,
		shapeLeftUp,
		shapeRightDown,
		shapeRightUp
	} pathShape;

	typedef enum logic [2:0] {
		classBlack,
		classBlue,
		classYellow,
		classBlueEdge,
		classBlueInner,
		classYellowEdge,
		classYellowInner
	} pixelClass;

	// Palette entries with red in index 2, green in 1 and blue in 0
	localparam colorByte [2:0] blueSolid = {8'd0, 8'd0, 8'd255};
	localparam colorByte [2:0] yellowSolid = {8'd255, 8'd255, 8'd0};
	localparam colorByte [2:0] blueEdge = {8'd0, 8'd162, 8'd230};
	localparam colorByte [2:0] blueInner = {8'd156, 8'd219, 8'd230};
	localparam colorByte [2:0] yellowEdge = {8'd255, 8'd201, 8'd14};
	localparam colorByte [2:0] yellowInner = {8'd255, 8'd254, 8'd145};

endpackage

`default_nettype wire

// File: tileAddressGen.sv
`timescale 1ns/100ps
`default_nettype none

module tileAddressGen (
	input wire logic clk,
	input wire logic reset,
	input wire logic bright,
	input wire bitGenPkg::coordWord hCount,
	input wire bitGenPkg::coordWord vCount,
	output bitGenPkg::coordWord memAddress,
	output bitGenPkg::pixelIndex posDelayed,
	output logic brightDelayed
);

	bitGenPkg::coordWord tileCol;
	bitGenPkg::coordWord tileRow;
	bitGenPkg::pixelIndex pixelPos;

	// Tile coordinates on the 160-wide tile map
	assign tileCol = hCount >> bitGenPkg::tileShift;
	assign tileRow = vCount >> bitGenPkg::tileShift;

	// Wraps modulo 2^16 like the memory address bus
	assign memAddress = bitGenPkg::tileMapBase + tileCol + tileRow * bitGenPkg::tilesPerRow;

	// Row bits on top give column plus four times the row
	assign pixelPos = {
		vCount[bitGenPkg::tileShift-1:0],
		hCount[bitGenPkg::tileShift-1:0]
	};

	// Memory answers one edge later, so hold position and blanking for one edge too
	always_ff @(posedge clk) begin
		if (reset) begin
			posDelayed <= '0;
			brightDelayed <= 1'b0;
		end else begin
			posDelayed <= pixelPos;
			brightDelayed <= bright;
		end
	end

endmodule

`default_nettype wire

// File: glyphShapeRom.sv
`timescale 1ns/100ps
`default_nettype none

module glyphShapeRom (
	input wire bitGenPkg::coordWord memData,
	input wire bitGenPkg::pixelIndex posDelayed,
	output bitGenPkg::pixelClass pixClass
);

	// Last code of each path range
	localparam bitGenPkg::coordWord blueLast =
		bitGenPkg::bluePathBase + bitGenPkg::coordWord'(bitGenPkg::shapeRightUp);
	localparam bitGenPkg::coordWord yellowLast =
		bitGenPkg::yellowPathBase + bitGenPkg::coordWord'(bitGenPkg::shapeRightUp);

	logic isBluePath;
	logic isYellowPath;
	bitGenPkg::coordWord pathOffset;
	bitGenPkg::pathShape shape;
	logic [15:0] shapeMask;
	logic onEdge;

	// Bit i set means in-tile pixel i belongs to the outer edge
	function automatic logic [15:0] edgeMask(input bitGenPkg::pathShape sel);
		logic [15:0] mask;
		case (sel)
			// Top and bottom rows
			bitGenPkg::shapeHorizontal: mask = 16'hF00F;
			// Left and right columns
			bitGenPkg::shapeVertical: mask = 16'h9999;
			// Full border
			bitGenPkg::shapeCorner: mask = 16'hF99F;
			// Top row, right column, bottom-left pixel
			bitGenPkg::shapeLeftDown: mask = 16'h988F;
			// Bottom row, right column, top-left pixel
			bitGenPkg::shapeLeftUp: mask = 16'hF889;
			// Top row, left column, bottom-right pixel
			bitGenPkg::shapeRightDown: mask = 16'h911F;
			// Bottom row, left column, top-right pixel
			bitGenPkg::shapeRightUp: mask = 16'hF119;
			default: mask = 16'h0000;
		endcase
		return mask;
	endfunction

	assign isBluePath = (memData >= bitGenPkg::bluePathBase) && (memData <= blueLast);
	assign isYellowPath = (memData >= bitGenPkg::yellowPathBase) && (memData <= yellowLast);

	always_comb begin
		if (isYellowPath) begin
			pathOffset = memData - bitGenPkg::yellowPathBase;
		end else begin
			pathOffset = memData - bitGenPkg::bluePathBase;
		end
	end

	// Offset is below 7 whenever a path range matched
	assign shape = bitGenPkg::pathShape'(pathOffset[2:0]);
	assign shapeMask = edgeMask(shape);
	assign onEdge = shapeMask[posDelayed];

	always_comb begin
		if (memData == bitGenPkg::glyphBlue) begin
			pixClass = bitGenPkg::classBlue;
		end else if (memData == bitGenPkg::glyphYellow) begin
			pixClass = bitGenPkg::classYellow;
		end else if (isBluePath) begin
			pixClass = onEdge ? bitGenPkg::classBlueEdge : bitGenPkg::classBlueInner;
		end else if (isYellowPath) begin
			pixClass = onEdge ? bitGenPkg::classYellowEdge : bitGenPkg::classYellowInner;
		end else begin
			// Black square, dropped bike codes and anything unknown
			pixClass = bitGenPkg::classBlack;
		end
	end

endmodule

`default_nettype wire

// File: pixelPalette.sv
`timescale 1ns/100ps
`default_nettype none

module pixelPalette (
	input wire logic clk,
	input wire logic reset,
	input wire bitGenPkg::pixelClass pixClass,
	input wire logic brightDelayed,
	output bitGenPkg::colorByte vgaRed,
	output bitGenPkg::colorByte vgaGreen,
	output bitGenPkg::colorByte vgaBlue
);

	bitGenPkg::colorByte [2:0] classColor;

	always_comb begin
		case (pixClass)
			bitGenPkg::classBlue: classColor = bitGenPkg::blueSolid;
			bitGenPkg::classYellow: classColor = bitGenPkg::yellowSolid;
			bitGenPkg::classBlueEdge: classColor = bitGenPkg::blueEdge;
			bitGenPkg::classBlueInner: classColor = bitGenPkg::blueInner;
			bitGenPkg::classYellowEdge: classColor = bitGenPkg::yellowEdge;
			bitGenPkg::classYellowInner: classColor = bitGenPkg::yellowInner;
			default: classColor = '0;
		endcase
	end

	// Blanking forces black on the output registers
	always_ff @(posedge clk) begin
		if (reset || !brightDelayed) begin
			vgaRed <= '0;
			vgaGreen <= '0;
			vgaBlue <= '0;
		end else begin
			vgaRed <= classColor[2];
			vgaGreen <= classColor[1];
			vgaBlue <= classColor[0];
		end
	end

endmodule

`default_nettype wire

// File: bitGen.sv
`timescale 1ns/100ps
`default_nettype none

module bitGen (
	input wire logic clk,
	input wire logic reset,
	input wire logic bright,
	input wire bitGenPkg::coordWord hCount,
	input wire bitGenPkg::coordWord vCount,
	input wire bitGenPkg::coordWord memData,
	output bitGenPkg::coordWord memAddress,
	output bitGenPkg::colorByte vgaRed,
	output bitGenPkg::colorByte vgaGreen,
	output bitGenPkg::colorByte vgaBlue
);

	bitGenPkg::pixelIndex posDelayed;
	logic brightDelayed;
	bitGenPkg::pixelClass pixClass;

	// Address out now, position and blanking one edge later with memData
	tileAddressGen addrGen (
		.clk(clk),
		.reset(reset),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.memAddress(memAddress),
		.posDelayed(posDelayed),
		.brightDelayed(brightDelayed)
	);

	glyphShapeRom shapeRom (
		.memData(memData),
		.posDelayed(posDelayed),
		.pixClass(pixClass)
	);

	// Second edge of the two-cycle pipeline
	pixelPalette palette (
		.clk(clk),
		.reset(reset),
		.pixClass(pixClass),
		.brightDelayed(brightDelayed),
		.vgaRed(vgaRed),
		.vgaGreen(vgaGreen),
		.vgaBlue(vgaBlue)
	);

endmodule

`default_nettype wire

// File: bitGen_chk.sv
`timescale 1ns/100ps
`default_nettype none

module bitGen_chk (
	input wire logic clk,
	input wire logic reset,
	input wire logic bright,
	input wire bitGenPkg::colorByte vgaRed,
	input wire bitGenPkg::colorByte vgaGreen,
	input wire bitGenPkg::colorByte vgaBlue
);

	logic assertFailed = 1'b0;
	logic rgbBlack;

	assign rgbBlack = (vgaRed == 8'd0) && (vgaGreen == 8'd0) && (vgaBlue == 8'd0);

	// Output registers clear on the edge that sees reset
	resetClearsRgb: assert property (@(posedge clk) reset |=> rgbBlack)
		else begin
			$error("RGB not zero in the cycle after reset");
			assertFailed = 1'b1;
		end

	// Pixel sampled at edge N is registered at N+1 and seen at N+2
	blankPixelBlack: assert property (@(posedge clk) disable iff (reset)
			!bright |-> ##2 rgbBlack)
		else begin
			$error("RGB not zero two edges after bright was sampled low");
			assertFailed = 1'b1;
		end

endmodule

bind bitGen bitGen_chk outputCheck (
	.clk(clk),
	.reset(reset),
	.bright(bright),
	.vgaRed(vgaRed),
	.vgaGreen(vgaGreen),
	.vgaBlue(vgaBlue)
);

`default_nettype wire

// File: bitGenTb.sv
`timescale 1ns/100ps
`default_nettype none

module bitGenTb;

	// Cycles allowed for the last pixels to leave the pipeline
	localparam int drainLimit = 20;

	logic clk;
	logic reset;
	logic bright;
	bitGenPkg::coordWord hCount;
	bitGenPkg::coordWord vCount;
	bitGenPkg::coordWord memData;
	bitGenPkg::coordWord memAddress;
	bitGenPkg::colorByte vgaRed;
	bitGenPkg::colorByte vgaGreen;
	bitGenPkg::colorByte vgaBlue;

	// Sparse tile map where unwritten words read as zero
	logic [15:0] tileMem [int];

	// Expected colors in flight and the edge count at which each is due
	logic [23:0] expQueue [$];
	int dueQueue [$];
	int edgeCount = 0;
	logic pixValid;
	logic [23:0] pixExpected;

	bitGen UUT (
		.clk(clk),
		.reset(reset),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.memData(memData),
		.memAddress(memAddress),
		.vgaRed(vgaRed),
		.vgaGreen(vgaGreen),
		.vgaBlue(vgaBlue)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Synchronous read with one edge of latency
	always @(posedge clk) begin
		if (tileMem.exists(int'(memAddress))) begin
			memData <= tileMem[int'(memAddress)];
		end else begin
			memData <= '0;
		end
	end

	// Output for a pixel sampled at edge N is registered at edge N+1
	always @(posedge clk) begin
		edgeCount = edgeCount + 1;
		if (!reset && pixValid) begin
			expQueue.push_back(pixExpected);
			dueQueue.push_back(edgeCount + 1);
		end
	end

	always @(negedge clk) begin : compareOutputs
		logic [23:0] want;
		if (dueQueue.size() > 0 && dueQueue[0] == edgeCount) begin
			want = expQueue.pop_front();
			void'(dueQueue.pop_front());
			checkEqual("vgaRed", want[23:16], vgaRed);
			checkEqual("vgaGreen", want[15:8], vgaGreen);
			checkEqual("vgaBlue", want[7:0], vgaBlue);
		end
	end

	task automatic checkEqual(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	function automatic logic [15:0] addressFor(input int hc, input int vc);
		int col;
		int row;
		col = (hc % 65536) / 4;
		row = (vc % 65536) / 4;
		return 16'((40000 + col + row * 160) % 65536);
	endfunction

	// Color from the glyph rules with pos as column plus four times the row
	function automatic logic [23:0] expectedColor(input int code, input int pos, input logic br);
		int row;
		int col;
		int shape;
		logic isEdge;
		logic [23:0] color;
		row = pos / 4;
		col = pos % 4;
		shape = -1;
		color = 24'h000000;
		if (code >= 3 && code <= 9) begin
			shape = code - 3;
		end else if (code >= 28 && code <= 34) begin
			shape = code - 28;
		end
		case (shape)
			0: isEdge = (row == 0) || (row == 3);
			1: isEdge = (col == 0) || (col == 3);
			2: isEdge = (row == 0) || (row == 3) || (col == 0) || (col == 3);
			3: isEdge = (row == 0) || (col == 3) || (pos == 12);
			4: isEdge = (row == 3) || (col == 3) || (pos == 0);
			5: isEdge = (row == 0) || (col == 0) || (pos == 15);
			6: isEdge = (row == 3) || (col == 0) || (pos == 3);
			default: isEdge = 1'b0;
		endcase
		if (code == 1) begin
			color = {8'd0, 8'd0, 8'd255};
		end else if (code == 2) begin
			color = {8'd255, 8'd255, 8'd0};
		end else if (code >= 3 && code <= 9) begin
			color = isEdge ? {8'd0, 8'd162, 8'd230} : {8'd156, 8'd219, 8'd230};
		end else if (code >= 28 && code <= 34) begin
			color = isEdge ? {8'd255, 8'd201, 8'd14} : {8'd255, 8'd254, 8'd145};
		end
		if (!br) begin
			color = 24'h000000;
		end
		return color;
	endfunction

	task automatic drivePixel(input int hc, input int vc, input logic br, input int code);
		logic [15:0] addr;
		addr = addressFor(hc, vc);
		@(negedge clk);
		tileMem[int'(addr)] = 16'(code);
		hCount = 16'(hc);
		vCount = 16'(vc);
		bright = br;
		pixExpected = expectedColor(code, (hc % 4) + 4 * (vc % 4), br);
		pixValid = 1'b1;
		#1;
		checkEqual("memAddress", addr, memAddress);
	endtask

	task automatic drainPipeline();
		int waited;
		@(negedge clk);
		pixValid = 1'b0;
		bright = 1'b0;
		waited = 0;
		#1;
		while (expQueue.size() > 0) begin
			if (waited >= drainLimit) begin
				$display("Timeout: %0d pixels never reached the outputs", expQueue.size());
				$display("=== FAIL ===");
				$fatal(1, "Pipeline did not drain");
			end
			@(negedge clk);
			#1;
			waited++;
		end
	endtask

	task automatic resetOutputsBlack();
		int n;
		// Second look covers the cleared blanking register
		for (n = 0; n < 2; n++) begin
			checkEqual("vgaRed", 0, vgaRed);
			checkEqual("vgaGreen", 0, vgaGreen);
			checkEqual("vgaBlue", 0, vgaBlue);
			@(negedge clk);
		end
	endtask

	task automatic addressMapping();
		int hcList [6] = '{0, 3, 4, 639, 640, 65535};
		int vcList [6] = '{0, 479, 3, 4, 65535, 480};
		int n;
		for (n = 0; n < 6; n++) begin
			drivePixel(hcList[n], vcList[n], 1'b1, n % 3);
		end
		for (n = 0; n < 24; n++) begin
			drivePixel($urandom_range(0, 65535), $urandom_range(0, 65535), 1'b1,
				$urandom_range(0, 2));
		end
		drainPipeline();
	endtask

	task automatic solidSquares();
		int code;
		int pos;
		// Back to back, one tile per code
		for (code = 0; code < 3; code++) begin
			for (pos = 0; pos < 16; pos++) begin
				drivePixel(40 + 4 * code + pos % 4, 20 + pos / 4, 1'b1, code);
			end
		end
		drainPipeline();
	endtask

	task automatic pathGlyphs();
		int code;
		int pos;
		for (code = 3; code <= 34; code++) begin
			if (code <= 9 || code >= 28) begin
				for (pos = 0; pos < 16; pos++) begin
					drivePixel(4 * code + pos % 4, 28 + pos / 4, 1'b1, code);
				end
			end
		end
		drainPipeline();
	endtask

	task automatic blankingForcesBlack();
		int codes [6] = '{1, 2, 3, 6, 29, 33};
		int n;
		int k;
		for (n = 0; n < 6; n++) begin
			for (k = 0; k < 8; k++) begin
				drivePixel(4 * (100 + n) + $urandom_range(0, 3), 240 + $urandom_range(0, 3),
					k >= 4, codes[n]);
			end
		end
		drainPipeline();
	endtask

	task automatic droppedCodesBlack();
		int code;
		int n;
		for (code = 10; code <= 52; code++) begin
			if (code <= 27 || code >= 35) begin
				drivePixel(4 * code + $urandom_range(0, 3), 300 + $urandom_range(0, 3),
					1'b1, code);
			end
		end
		drivePixel(0, 320, 1'b1, 53);
		for (n = 0; n < 20; n++) begin
			drivePixel(4 * n + $urandom_range(0, 3), 324 + $urandom_range(0, 3), 1'b1,
				$urandom_range(53, 65535));
		end
		drainPipeline();
	endtask

	initial begin
		void'($urandom(90230));
		reset = 1'b1;
		bright = 1'b0;
		hCount = '0;
		vCount = '0;
		memData = '0;
		pixValid = 1'b0;
		pixExpected = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		resetOutputsBlack();
		addressMapping();
		solidSquares();
		pathGlyphs();
		blankingForcesBlack();
		droppedCodesBlack();
		repeat (4) @(negedge clk);
		if (UUT.outputCheck.assertFailed) begin
			$display("Assertion failure reported by bitGen_chk");
			$display("=== FAIL ===");
			$fatal(1, "Assertion failed during the run");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

	initial begin
		#100000;
		$display("Simulation ran past its time limit");
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

// File: bitGen.f
bitGenPkg.sv
tileAddressGen.sv
glyphShapeRom.sv
pixelPalette.sv
bitGen.sv
bitGen_chk.sv
bitGenTb.sv

// File: Bender.yml
package:
  name: bitGen

sources:
  - bitGenPkg.sv
  - tileAddressGen.sv
  - glyphShapeRom.sv
  - pixelPalette.sv
  - bitGen.sv
  - target: test
    files:
      - bitGen_chk.sv
      - bitGenTb.sv
